//--- common/wb_params.svh
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////////////////////////

`define WB_AW        32           // Address width, both sides
`define WB_MDW       32           // Master data width
`define WB_SDW       8            // Slave data width
`define WB_SELW      4            // Master byte enables

// Cycle type fields, carried through only
`define WB_CTIW      3
`define WB_BTEW      2

//////////////////////////////////////////////////////////////////////
// Register bank
//////////////////////////////////////////////////////////////////////

`define BANK_BYTES   64           // Window size in bytes
`define BANK_ID      8'hA5        // Read-only ID at byte 0

`endif // WB_PARAMS_SVH

//--- common/wb_pkg.sv
`include "wb_params.svh"

package wb_pkg;

  // Widths with a meaning of their own
  typedef logic [`WB_AW-1:0]   wb_adr_t;   // Byte address
  typedef logic [`WB_MDW-1:0]  wb_mdat_t;  // Master data word
  typedef logic [`WB_SDW-1:0]  wb_sdat_t;  // Slave data byte
  typedef logic [`WB_SELW-1:0] wb_sel_t;   // Byte enables
  typedef logic [$clog2(`BANK_BYTES)-1:0] bank_idx_t;  // Bank byte index

  //////////////////////////////////////////////////////////////////////
  // 32-bit master side
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    wb_adr_t             adr;
    wb_mdat_t            dat;   // Write data
    wb_sel_t             sel;
    logic                we;
    logic                cyc;
    logic                stb;
    logic [`WB_CTIW-1:0] cti;   // Burst info, not acted on
    logic [`WB_BTEW-1:0] bte;
  } wbm_req_t;

  typedef struct packed {
    wb_mdat_t dat;              // Read data
    logic     ack;
    logic     err;
    logic     rty;
  } wbm_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // 8-bit slave side
  //////////////////////////////////////////////////////////////////////

  // Same as master request, single lane and no sel
  typedef struct packed {
    wb_adr_t             adr;
    wb_sdat_t            dat;
    logic                we;
    logic                cyc;
    logic                stb;
    logic [`WB_CTIW-1:0] cti;
    logic [`WB_BTEW-1:0] bte;
  } wbs_req_t;

  typedef struct packed {
    wb_sdat_t dat;
    logic     ack;
    logic     err;
    logic     rty;
  } wbs_rsp_t;

endpackage

//--- hdl/byte_regs/byte_reg_bank.sv
`timescale 1ns/100ps

`include "wb_params.svh"

module byte_reg_bank
  import wb_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,

  // 8-bit Wishbone slave, classic cycles only
  input  wbs_req_t wbs_req_i,
  output wbs_rsp_t wbs_rsp_o
);

  // Bytes 1..63, byte 0 is the constant ID
  wb_sdat_t  mem [1:`BANK_BYTES-1];

  bank_idx_t idx;         // Byte addressed by this cycle
  logic      is_id;       // Byte 0
  logic      is_lock;     // Byte 1
  logic      locked;      // Lock bit 0
  logic      rsp_pend;    // Response out this cycle
  logic      access;      // New cycle accepted
  logic      wr_id;       // Write to ID, ends in err
  logic      wr_blocked;  // Scratch write under lock, ends in rty
  logic      wr_ok;       // Write that lands
  wb_sdat_t  rd_byte;     // Read mux output

  logic      ack_q;
  logic      err_q;
  logic      rty_q;
  wb_sdat_t  rdat_q;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  assign idx      = bank_idx_t'(wbs_req_i.adr);  // Upper bits checked upstream
  assign is_id    = (idx == bank_idx_t'(0));
  assign is_lock  = (idx == bank_idx_t'(1));
  assign locked   = mem[1][0];

  // One cycle in flight; the held request is ignored while answering
  assign rsp_pend = ack_q | err_q | rty_q;
  assign access   = wbs_req_i.cyc & wbs_req_i.stb & ~rsp_pend;

  assign wr_id      = wbs_req_i.we & is_id;
  assign wr_blocked = wbs_req_i.we & ~is_id & ~is_lock & locked;
  assign wr_ok      = access & wbs_req_i.we & ~wr_id & ~wr_blocked;

  always_comb begin
    if (is_id) begin
      rd_byte = `BANK_ID;
    end else begin
      rd_byte = mem[idx];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Storage and response
  //////////////////////////////////////////////////////////////////////

  // Lock and scratch come up as zero
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < `BANK_BYTES; i++) begin
        mem[i] <= '0;
      end
      ack_q <= 1'b0;
      err_q <= 1'b0;
      rty_q <= 1'b0;
    end else begin
      if (wr_ok) begin
        mem[idx] <= wbs_req_i.dat;      // Lock byte included
      end
      ack_q <= access & ~wr_id & ~wr_blocked;   // Reads always ack
      err_q <= access & wr_id;
      rty_q <= access & wr_blocked;
    end
  end

  // Read data valid only alongside a read ack, zero otherwise
  always_ff @(posedge clk_i) begin
    if (access & ~wbs_req_i.we) begin
      rdat_q <= rd_byte;
    end else begin
      rdat_q <= '0;
    end
  end

  assign wbs_rsp_o.dat = rdat_q;
  assign wbs_rsp_o.ack = ack_q;
  assign wbs_rsp_o.err = err_q;
  assign wbs_rsp_o.rty = rty_q;

endmodule

//--- hdl/periph_wb_subsys.sv
`timescale 1ns/100ps

module periph_wb_subsys
  import wb_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,

  // External 32-bit Wishbone port
  input  wbm_req_t wbm_req_i,
  output wbm_rsp_t wbm_rsp_o
);

  //////////////////////////////////////////////////////////////////////
  // Internal buses
  //////////////////////////////////////////////////////////////////////

  wbm_req_t dec_req;     // Decoder to resizer, 32-bit
  wbm_rsp_t dec_rsp;
  wbs_req_t bank_req;    // Resizer to bank, 8-bit
  wbs_rsp_t bank_rsp;

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  // Misses stop here with err
  wb_addr_decode i_decode (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wbm_req_i (wbm_req_i),
    .wbm_rsp_o (wbm_rsp_o),
    .fwd_req_o (dec_req),
    .fwd_rsp_i (dec_rsp)
  );

  //////////////////////////////////////////////////////////////////////
  // 32 to 8 lane narrowing
  //////////////////////////////////////////////////////////////////////

  wb_data_resize i_resize (
    .wbm_req_i (dec_req),
    .wbm_rsp_o (dec_rsp),
    .wbs_req_o (bank_req),
    .wbs_rsp_i (bank_rsp)
  );

  //////////////////////////////////////////////////////////////////////
  // Register bank
  //////////////////////////////////////////////////////////////////////

  byte_reg_bank i_bank (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wbs_req_i (bank_req),
    .wbs_rsp_o (bank_rsp)
  );

endmodule

//--- hdl/wb_addr_decode.sv
`timescale 1ns/100ps

`include "wb_params.svh"

module wb_addr_decode
  import wb_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,

  // External 32-bit master
  input  wbm_req_t wbm_req_i,
  output wbm_rsp_t wbm_rsp_o,

  // Toward the resizer
  output wbm_req_t fwd_req_o,
  input  wbm_rsp_t fwd_rsp_i
);

  logic in_win;     // Address falls in the bank window
  logic miss_req;   // Live cycle outside the window
  logic err_q;      // Decoder's own err pulse

  //////////////////////////////////////////////////////////////////////
  // Window check
  //////////////////////////////////////////////////////////////////////

  // Window starts at address zero
  assign in_win   = (wbm_req_i.adr < wb_adr_t'(`BANK_BYTES));
  assign miss_req = wbm_req_i.cyc & wbm_req_i.stb & ~in_win;

  //////////////////////////////////////////////////////////////////////
  // Forward path
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    fwd_req_o     = wbm_req_i;                  // Combinational pass
    fwd_req_o.stb = wbm_req_i.stb & in_win;     // Block missed cycles
  end

  //////////////////////////////////////////////////////////////////////
  // Miss response
  //////////////////////////////////////////////////////////////////////

  // err_q doubles as the pending flag.
  // While it is high the held request is not answered again, so the
  // master sees a one-cycle pulse and the next miss waits one cycle.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= miss_req & ~err_q;
    end
  end

  // Merge own err into the bank path
  always_comb begin
    wbm_rsp_o     = fwd_rsp_i;                  // Data, ack, rty as-is
    wbm_rsp_o.err = fwd_rsp_i.err | err_q;
  end

endmodule

//--- hdl/wb_resize/wb_data_resize.sv
`timescale 1ns/100ps

`include "wb_params.svh"

module wb_data_resize
  import wb_pkg::*;
(
  // 32-bit master side
  input  wbm_req_t wbm_req_i,
  output wbm_rsp_t wbm_rsp_o,

  // 8-bit slave side
  output wbs_req_t wbs_req_o,
  input  wbs_rsp_t wbs_rsp_i
);

  logic [1:0] lane_ofs;   // Byte offset of the served lane
  wb_sdat_t   wr_byte;    // Write byte taken from that lane
  wb_mdat_t   rd_word;    // Read byte placed back in its lane

  //////////////////////////////////////////////////////////////////////
  // Lane select by highest sel bit
  //////////////////////////////////////////////////////////////////////

  // Big-endian lanes with sel[3] as byte 0 of the word
  always_comb begin
    if (wbm_req_i.sel[3]) begin
      lane_ofs = 2'd0;
      wr_byte  = wbm_req_i.dat[31:24];
    end else if (wbm_req_i.sel[2]) begin
      lane_ofs = 2'd1;
      wr_byte  = wbm_req_i.dat[23:16];
    end else if (wbm_req_i.sel[1]) begin
      lane_ofs = 2'd2;
      wr_byte  = wbm_req_i.dat[15:8];
    end else if (wbm_req_i.sel[0]) begin
      lane_ofs = 2'd3;
      wr_byte  = wbm_req_i.dat[7:0];
    end else begin
      lane_ofs = 2'd3;            // No lane selects the last byte
      wr_byte  = '0;              // Written as zero
    end
  end

  // Read lane follows the same priority
  always_comb begin
    rd_word = '0;
    if (wbm_req_i.sel[3]) begin
      rd_word[31:24] = wbs_rsp_i.dat;
    end else if (wbm_req_i.sel[2]) begin
      rd_word[23:16] = wbs_rsp_i.dat;
    end else if (wbm_req_i.sel[1]) begin
      rd_word[15:8]  = wbs_rsp_i.dat;
    end else begin
      rd_word[7:0]   = wbs_rsp_i.dat;   // sel[0] or none
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Slave request
  //////////////////////////////////////////////////////////////////////

  assign wbs_req_o.adr = {wbm_req_i.adr[`WB_AW-1:2], lane_ofs};
  assign wbs_req_o.dat = wr_byte;
  assign wbs_req_o.we  = wbm_req_i.we;
  assign wbs_req_o.cyc = wbm_req_i.cyc;
  assign wbs_req_o.stb = wbm_req_i.stb;
  assign wbs_req_o.cti = wbm_req_i.cti;     // Burst fields untouched
  assign wbs_req_o.bte = wbm_req_i.bte;

  //////////////////////////////////////////////////////////////////////
  // Master response
  //////////////////////////////////////////////////////////////////////

  assign wbm_rsp_o.dat = rd_word;
  assign wbm_rsp_o.ack = wbs_rsp_i.ack;
  assign wbm_rsp_o.err = wbs_rsp_i.err;
  assign wbm_rsp_o.rty = wbs_rsp_i.rty;

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

TOP=tb_periph_wb_subsys
OBJ=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f sources.f --top-module "$TOP" -Mdir "$OBJ" -o "V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Build failed with status $status"
  exit 1
fi

"./$OBJ/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

grep -q "Regression failed" "$LOG"
found=$?
if [ "$found" -eq 0 ]; then
  echo "Simulation reported failure, see $LOG"
  exit 1
fi
if [ "$found" -ne 1 ]; then
  echo "Could not search $LOG"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

//--- sources.f
+incdir+common
common/wb_pkg.sv
hdl/wb_addr_decode.sv
hdl/wb_resize/wb_data_resize.sv
hdl/byte_regs/byte_reg_bank.sv
hdl/periph_wb_subsys.sv
verif/tb_periph_wb_subsys.sv

//--- verif/tb_periph_wb_subsys.sv
`timescale 1ns/100ps

`include "wb_params.svh"

module tb_periph_wb_subsys
  import wb_pkg::*;
();

  localparam int CLK_HALF  = 20;                 // 40 ns period
  localparam int N_SCAN    = `BANK_BYTES + 1;    // Every byte, then the ID write
  localparam int N_RAND    = 24;
  localparam int N_MULTI   = 16;
  localparam int N_LOCK    = 6;
  localparam int N_MISS    = 8;
  localparam int N_B2B     = 16;
  localparam int N_TRANS   = N_SCAN + 2 * N_RAND + 2 * N_MULTI + 3 + 4 * N_LOCK
                             + 3 * N_MISS + N_B2B;
  localparam int CYC_LIMIT = N_TRANS * 4 + 100;

  // Response kinds as {ack, err, rty}
  localparam logic [2:0] RSP_ACK = 3'b100;
  localparam logic [2:0] RSP_ERR = 3'b010;
  localparam logic [2:0] RSP_RTY = 3'b001;

  logic        clk_i = 1'b0;
  logic        rst_i;
  wbm_req_t    wbm_req;
  wbm_rsp_t    wbm_rsp;
  logic [2:0]  got_kind;

  integer      seed      = 32'hf0cd;
  int          err_cnt   = 0;     // Wrong values
  int          proto_cnt = 0;     // Handshake faults
  int          cyc_cnt   = 0;

  // Cycle in flight, shared with the compare process
  string       cur_name = "";
  logic [2:0]  exp_kind = '0;
  wb_mdat_t    exp_dat  = '0;
  bit          pend     = 1'b0;
  int          wait_cyc = 0;

  logic [7:0]  ref_mem [0:`BANK_BYTES-1];   // Model of the bank contents
  int          byte_q [$];

  periph_wb_subsys i_dut (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wbm_req_i (wbm_req),
    .wbm_rsp_o (wbm_rsp)
  );

  always #CLK_HALF clk_i = ~clk_i;

  assign got_kind = {wbm_rsp.ack, wbm_rsp.err, wbm_rsp.rty};

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Applies lane priority and bank rules, updates the model on a write
  function automatic void ref_access(input wb_adr_t adr, input logic we,
                                     input wb_mdat_t dat, input wb_sel_t sel,
                                     output logic [2:0] kind, output wb_mdat_t rdat);
    logic [1:0] ofs;
    logic [7:0] wbyte;
    logic [5:0] idx;
    logic [7:0] rbyte;
    kind = RSP_ACK;
    rdat = '0;                             // Zero unless a read lands
    casez (sel)
      4'b1???: begin
        ofs   = 2'd0;
        wbyte = dat[31:24];
      end
      4'b01??: begin
        ofs   = 2'd1;
        wbyte = dat[23:16];
      end
      4'b001?: begin
        ofs   = 2'd2;
        wbyte = dat[15:8];
      end
      4'b0001: begin
        ofs   = 2'd3;
        wbyte = dat[7:0];
      end
      default: begin
        ofs   = 2'd3;                      // No lane, last byte gets zero
        wbyte = 8'h00;
      end
    endcase
    idx = {adr[5:2], ofs};
    if (adr >= wb_adr_t'(`BANK_BYTES)) begin
      kind = RSP_ERR;                      // Decoder miss, bank untouched
    end else if (we) begin
      if (idx == 6'd0) begin
        kind = RSP_ERR;                    // ID is read-only
      end else if (idx != 6'd1 && ref_mem[1][0]) begin
        kind = RSP_RTY;                    // Scratch locked
      end else begin
        ref_mem[idx] = wbyte;
      end
    end else begin
      rbyte = (idx == 6'd0) ? `BANK_ID : ref_mem[idx];
      casez (sel)
        4'b1???: rdat[31:24] = rbyte;
        4'b01??: rdat[23:16] = rbyte;
        4'b001?: rdat[15:8]  = rbyte;
        default: rdat[7:0]   = rbyte;      // sel[0] or none
      endcase
    end
  endfunction

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  // Single sel bit for a byte, sel[3] is byte 0 of the word
  function automatic wb_sel_t byte_sel(input int b);
    return wb_sel_t'(4'b1000 >> (b % 4));
  endfunction

  function automatic wb_mdat_t lane_dat(input int b, input logic [7:0] v);
    return wb_mdat_t'({v, 24'h000000}) >> (8 * (b % 4));
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Bus driver
  //////////////////////////////////////////////////////////////////////

  task automatic bus_cycle(input string name, input wb_adr_t adr, input logic we,
                           input wb_mdat_t dat, input wb_sel_t sel);
    @(posedge clk_i);
    wbm_req.adr <= adr;
    wbm_req.dat <= dat;
    wbm_req.sel <= sel;
    wbm_req.we  <= we;
    wbm_req.cyc <= 1'b1;
    wbm_req.stb <= 1'b1;
    wbm_req.cti <= 3'b000;                 // Classic cycle
    wbm_req.bte <= 2'b00;
    cur_name = name;
    ref_access(adr, we, dat, sel, exp_kind, exp_dat);
    wait_cyc = 0;
    pend     = 1'b1;
    wait (!pend);                          // Cleared by the compare process
  endtask

  task automatic bus_idle();
    @(posedge clk_i);
    wbm_req.cyc <= 1'b0;
    wbm_req.stb <= 1'b0;
    wbm_req.we  <= 1'b0;
  endtask

  task automatic bus_single(input string name, input wb_adr_t adr, input logic we,
                            input wb_mdat_t dat, input wb_sel_t sel);
    bus_cycle(name, adr, we, dat, sel);
    bus_idle();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare process and timeout
  //////////////////////////////////////////////////////////////////////

  // Sampled mid-cycle: first point is the request cycle, second the response
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (pend) begin
        wait_cyc = wait_cyc + 1;
        if (got_kind != 3'b000) begin
          assert ($onehot(got_kind)) else begin
            proto_cnt++;
            $display("%s: more than one of ack, err and rty raised at once", cur_name);
          end
          assert (wait_cyc == 2) else begin
            proto_cnt++;
            $display("%s: response did not come one cycle after the request", cur_name);
          end
          assert (got_kind == exp_kind) else begin
            err_cnt++;
            $display("mismatch %s: ack/err/rty expected %b actual %b",
                     cur_name, exp_kind, got_kind);
          end
          assert (wbm_rsp.dat == exp_dat) else begin
            err_cnt++;
            $display("mismatch %s: data expected %08h actual %08h",
                     cur_name, exp_dat, wbm_rsp.dat);
          end
          pend = 1'b0;
        end else begin
          assert (wait_cyc != 2) else begin
            proto_cnt++;
            $display("%s: no response one cycle after the request", cur_name);
          end
        end
      end else begin
        assert (got_kind == 3'b000) else begin
          proto_cnt++;
          if (!wbm_req.stb) begin
            $display("%s: response pulse while stb is low", cur_name);
          end else begin
            $display("%s: second response pulse for one cycle", cur_name);
          end
        end
      end
    end
  end

  task automatic print_counts();
    $display("Errors: %0d value mismatches, %0d protocol errors", err_cnt, proto_cnt);
  endtask

  always @(posedge clk_i) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= CYC_LIMIT) begin
      $display("Timeout after %0d cycles, the bus stopped answering", cyc_cnt);
      print_counts();
      $display("Regression failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic scan_after_reset();
    for (int b = 0; b < `BANK_BYTES; b++) begin
      bus_single("reset_read", wb_adr_t'(b), 1'b0, '0, byte_sel(b));
    end
    bus_single("id_write", 32'd0, 1'b1, 32'hff00_0000, 4'b1000);
  endtask

  task automatic random_write_read();
    logic [31:0] r;
    int          b;
    byte_q.delete();
    for (int k = 0; k < N_RAND; k++) begin
      r = next_rand();
      b = 2 + int'(r[15:0]) % 62;          // Scratch only, lock stays clear
      byte_q.push_back(b);
      bus_single("rand_write", wb_adr_t'(b), 1'b1, lane_dat(b, r[31:24]), byte_sel(b));
    end
    foreach (byte_q[i]) begin
      bus_single("rand_read", wb_adr_t'(byte_q[i]), 1'b0, '0, byte_sel(byte_q[i]));
    end
  endtask

  task automatic multi_sel_lanes();
    logic [31:0] r;
    wb_adr_t     adr;
    wb_sel_t     sel;
    for (int k = 0; k < N_MULTI; k++) begin
      r   = next_rand();
      adr = wb_adr_t'(4 * (1 + int'(r[3:0]) % 15));   // Skip the ID word
      sel = r[7:4];
      if (k == 0) sel = 4'b0000;
      if (k == 1) sel = 4'b1111;
      bus_single("multi_write", adr, 1'b1, next_rand(), sel);
      bus_single("multi_read", adr, 1'b0, '0, sel);
    end
  endtask

  task automatic lock_check();
    logic [31:0] r;
    int          b;
    bus_single("lock_set", 32'd1, 1'b1, lane_dat(1, 8'h01), byte_sel(1));
    bus_single("lock_read", 32'd1, 1'b0, '0, byte_sel(1));
    byte_q.delete();
    for (int k = 0; k < N_LOCK; k++) begin
      r = next_rand();
      b = 2 + 9 * k + int'(r[2:0]);
      byte_q.push_back(b);
      bus_single("locked_write", wb_adr_t'(b), 1'b1, lane_dat(b, r[31:24]), byte_sel(b));
    end
    foreach (byte_q[i]) begin
      bus_single("locked_read", wb_adr_t'(byte_q[i]), 1'b0, '0, byte_sel(byte_q[i]));
    end
    bus_single("lock_clear", 32'd1, 1'b1, lane_dat(1, 8'h00), byte_sel(1));
    foreach (byte_q[i]) begin
      r = next_rand();
      bus_single("unlocked_write", wb_adr_t'(byte_q[i]), 1'b1,
                 lane_dat(byte_q[i], r[31:24]), byte_sel(byte_q[i]));
    end
    foreach (byte_q[i]) begin
      bus_single("unlocked_read", wb_adr_t'(byte_q[i]), 1'b0, '0, byte_sel(byte_q[i]));
    end
  endtask

  // Alias read checks that the byte under the low address bits is unchanged
  task automatic window_miss();
    logic [31:0] r;
    wb_adr_t     adr;
    wb_sel_t     sel;
    for (int k = 0; k < N_MISS; k++) begin
      r   = next_rand();
      adr = r | 32'h0000_0040;             // Always past the window
      if (k == 0) adr = wb_adr_t'(`BANK_BYTES);
      sel = wb_sel_t'(4'b1000 >> r[9:8]);
      bus_single("miss_write", adr, 1'b1, next_rand(), sel);
      bus_single("miss_read", adr, 1'b0, '0, sel);
      bus_single("alias_read", {26'd0, adr[5:0]}, 1'b0, '0, sel);
    end
  endtask

  task automatic back_to_back();
    logic [31:0] r;
    int          b;
    b = 2;
    for (int k = 0; k < N_B2B; k++) begin
      r = next_rand();
      case (k % 4)
        0: begin
          b = 2 + int'(r[5:0]) % 62;
          bus_cycle("b2b_write", wb_adr_t'(b), 1'b1, lane_dat(b, r[31:24]), byte_sel(b));
        end
        1: bus_cycle("b2b_read", wb_adr_t'(b), 1'b0, '0, byte_sel(b));
        2: bus_cycle("b2b_miss", r | 32'h0000_0040, 1'b0, '0, 4'b0001);
        default: bus_cycle("b2b_id_write", 32'd0, 1'b1, r, 4'b1000);
      endcase
    end
    bus_idle();
  endtask

  initial begin
    rst_i   <= 1'b1;
    wbm_req <= '0;
    ref_mem = '{default: 8'h00};
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;

    scan_after_reset();
    random_write_read();
    multi_sel_lanes();
    lock_check();
    window_miss();
    back_to_back();

    repeat (2) @(posedge clk_i);           // Catch late pulses
    print_counts();
    if (err_cnt == 0 && proto_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
